//--- histo_pkg.sv
`default_nettype none

package histo_pkg;

    //////////////////////////////
    // Sizes and address map.
    //////////////////////////////
    localparam int POINTS     = 16;                 // Ring entries.
    localparam int PLOT_W     = 32;                 // Plot width in pixels.
    localparam int QUADS      = PLOT_W / 4;         // Bursts per row.
    localparam int RING_BASE  = 0;                  // Burst address of entry 0.
    localparam int FRAME_BASE = 16;                 // Burst address of row 0.
    localparam int MEM_DEPTH  = FRAME_BASE + POINTS * QUADS;
    localparam int ADDR_W     = 8;

    localparam int PTR_W  = $clog2(POINTS);         // Ring index width.
    localparam int QUAD_W = $clog2(QUADS);          // Burst-in-row width.
    localparam int LEN_W  = $clog2(PLOT_W) + 1;     // Bar length, 0 to PLOT_W.

    //////////////////////////////
    // RGB565 colours.
    //////////////////////////////
    localparam logic [15:0] COLOR_BG  = 16'h0000;   // Black.
    localparam logic [15:0] COLOR_BAR = 16'hF81F;   // Pink.

    //////////////////////////////
    // Burst word views.
    //////////////////////////////
    typedef struct packed {
        logic [47:0] pad;                           // Zero in every record.
        logic [15:0] count;                         // Shares the bits of pixel 0.
    } sample_rec_t;

    // Element 0 is the leftmost pixel.
    typedef logic [3:0][15:0] pixel_quad_t;

    typedef union packed {
        sample_rec_t sample;                        // Ring region.
        pixel_quad_t pix;                           // Frame region.
    } burst_word_u;

    typedef struct packed {
        logic              req;                     // Held until done.
        logic              we;
        logic [ADDR_W-1:0] addr;
        burst_word_u       wdata;
    } mem_req_t;

    typedef struct packed {
        logic        done;                          // One-cycle pulse.
        burst_word_u rdata;                         // Valid with done.
    } mem_rsp_t;

    typedef struct packed {
        logic             logged;                   // Record of this frame written.
        logic [PTR_W-1:0] head;                     // Oldest entry after the write.
    } ring_pos_t;

endpackage

`default_nettype wire

//--- sample_logger.sv
`timescale 1ns/1ps
`default_nettype none

module sample_logger (
    input  logic                 clk,
    input  logic                 rst_n,
    input  logic                 en,
    input  logic                 data_update,
    input  logic [15:0]          pulse_count,
    input  logic                 frame_start,
    output histo_pkg::ring_pos_t ring_pos,
    output histo_pkg::mem_req_t  mem_req,
    input  histo_pkg::mem_rsp_t  mem_rsp
);
    import histo_pkg::*;

    logic [15:0]      count_q;       // Last strobed count.
    logic [15:0]      rec_count_q;   // Count being written this frame.
    logic [PTR_W-1:0] head_q;        // Oldest entry and next write slot.
    logic             req_q;
    logic             logged_q;
    burst_word_u      rec_word;

    // Count latch keeps listening while frozen.
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            count_q <= '0;
        end else if (data_update) begin
            count_q <= pulse_count;
        end
    end

    //////////////////////////////
    // Record write per frame.
    //////////////////////////////
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            head_q   <= '0;
            req_q    <= 1'b0;
            logged_q <= 1'b0;
        end else if (en) begin
            logged_q <= 1'b0;                       // Pulse.
            if (req_q) begin
                if (mem_rsp.done) begin
                    req_q    <= 1'b0;
                    logged_q <= 1'b1;
                    head_q   <= (head_q == PTR_W'(POINTS - 1)) ? '0 : head_q + 1'b1;
                end
            end else if (frame_start) begin
                req_q <= 1'b1;                      // Overwrites the oldest entry.
            end
        end
    end

    // Snapshot at frame start. Later strobes wait for the next frame.
    always_ff @(posedge clk) begin
        if (en && frame_start && !req_q) begin
            rec_count_q <= count_q;
        end
    end

    always_comb begin
        rec_word              = '0;                 // Pad words stay zero.
        rec_word.sample.count = rec_count_q;
    end

    assign mem_req  = '{req: req_q, we: 1'b1,
                        addr: ADDR_W'(RING_BASE) + ADDR_W'(head_q), wdata: rec_word};
    assign ring_pos = '{logged: logged_q, head: head_q};

    // Ring index in range.
    a_head_range: assert property (@(posedge clk) disable iff (!rst_n)
        int'(head_q) < POINTS);

endmodule

`default_nettype wire

//--- burst_ram.sv
`timescale 1ns/1ps
`default_nettype none

module burst_ram (
    input  logic                         clk,
    input  logic                         rst_n,
    input  histo_pkg::mem_req_t          log_req,
    output histo_pkg::mem_rsp_t          log_rsp,
    input  histo_pkg::mem_req_t          paint_req,
    output histo_pkg::mem_rsp_t          paint_rsp,
    input  logic [histo_pkg::ADDR_W-1:0] scan_addr,
    output histo_pkg::burst_word_u       scan_data
);
    import histo_pkg::*;

    burst_word_u       mem [MEM_DEPTH];             // One burst per entry.

    logic              clearing_q;                  // Power-on fill running.
    logic [ADDR_W-1:0] clr_addr_q;
    burst_word_u       clr_word;

    logic              log_done_q;
    logic              paint_done_q;
    burst_word_u       rdata_q;                     // Shared read return.

    logic              log_sel;                     // Logger wins a tie.
    logic              accept;
    mem_req_t          sel_req;

    //////////////////////////////
    // Power-on clear.
    //////////////////////////////
    always_comb begin
        clr_word = '0;                              // Zero record in the ring.
        if (clr_addr_q >= ADDR_W'(FRAME_BASE)) begin
            clr_word.pix = {4{COLOR_BG}};           // Background quad in the frame.
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            clearing_q <= 1'b1;
            clr_addr_q <= '0;
        end else if (clearing_q) begin
            if (clr_addr_q == ADDR_W'(MEM_DEPTH - 1)) begin
                clearing_q <= 1'b0;                 // Last burst filled.
            end
            clr_addr_q <= clr_addr_q + 1'b1;
        end
    end

    //////////////////////////////
    // Fixed-priority arbiter.
    //////////////////////////////
    assign log_sel = log_req.req;
    assign sel_req = log_sel ? log_req : paint_req;

    // No accept while clearing or while a done is out.
    assign accept = !clearing_q && !log_done_q && !paint_done_q
                 && (log_req.req || paint_req.req);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            log_done_q   <= 1'b0;
            paint_done_q <= 1'b0;
        end else begin
            log_done_q   <= accept && log_sel;
            paint_done_q <= accept && !log_sel;
        end
    end

    //////////////////////////////
    // Storage and read ports.
    //////////////////////////////
    always_ff @(posedge clk) begin
        if (clearing_q) begin
            mem[clr_addr_q] <= clr_word;
        end else if (accept && sel_req.we) begin
            mem[sel_req.addr] <= sel_req.wdata;
        end
        if (accept) begin
            rdata_q <= mem[sel_req.addr];           // Ready with done.
        end
        // Scan-out ignores the clients. Out of range reads zero.
        scan_data <= (scan_addr < ADDR_W'(MEM_DEPTH)) ? mem[scan_addr] : '0;
    end

    assign log_rsp   = '{done: log_done_q,   rdata: rdata_q};
    assign paint_rsp = '{done: paint_done_q, rdata: rdata_q};

    // One client answered at a time.
    a_one_done: assert property (@(posedge clk) disable iff (!rst_n)
        !(log_rsp.done && paint_rsp.done));

    // Accepted bursts inside the array.
    a_addr_range: assert property (@(posedge clk) disable iff (!rst_n)
        accept |-> (sel_req.addr < ADDR_W'(MEM_DEPTH)));

endmodule

`default_nettype wire

//--- trace_painter.sv
`timescale 1ns/1ps
`default_nettype none

module trace_painter (
    input  logic                 clk,
    input  logic                 rst_n,
    input  logic                 en,
    input  logic [1:0]           gain_div,
    output logic                 frame_start,
    input  histo_pkg::ring_pos_t ring_pos,
    output histo_pkg::mem_req_t  mem_req,
    input  histo_pkg::mem_rsp_t  mem_rsp,
    output logic                 frame_done,
    output logic [15:0]          max_count,
    output logic [15:0]          min_count
);
    import histo_pkg::*;

    typedef enum logic [2:0] {
        S_START,                                    // Kick the logger.
        S_LOG,                                      // Wait for the new record.
        S_READ,                                     // Ring read in flight.
        S_BAR,                                      // Bar length and extremes.
        S_WRITE,                                    // Pixel burst in flight.
        S_NEXT,                                     // Step burst or row.
        S_DONE
    } state_t;

    state_t            state_q;
    logic [PTR_W-1:0]  head_q;                      // Oldest entry this frame.
    logic [PTR_W-1:0]  row_q;
    logic [QUAD_W-1:0] quad_q;
    logic [15:0]       count_q;                     // Count of the current row.
    logic [LEN_W-1:0]  bar_len_q;
    logic [15:0]       run_max_q;
    logic [15:0]       run_min_q;

    logic [PTR_W-1:0]  ring_idx;
    logic [ADDR_W-1:0] ring_addr;
    logic [ADDR_W-1:0] frame_addr;
    logic [15:0]       shifted;
    logic [LEN_W-1:0]  bar_next;
    logic              is_write;
    burst_word_u       quad_word;

    //////////////////////////////
    // Address and pixel datapath.
    //////////////////////////////
    assign ring_idx   = head_q + row_q;             // Wraps mod POINTS.
    assign ring_addr  = ADDR_W'(RING_BASE) + ADDR_W'(ring_idx);
    assign frame_addr = ADDR_W'(FRAME_BASE) + ADDR_W'(row_q) * ADDR_W'(QUADS)
                      + ADDR_W'(quad_q);

    assign shifted  = count_q >> gain_div;          // Divide by 2**gain_div.
    assign bar_next = (shifted > 16'(PLOT_W)) ? LEN_W'(PLOT_W) : shifted[LEN_W-1:0];

    always_comb begin
        quad_word = '0;
        for (int k = 0; k < 4; k++) begin
            if (int'(quad_q) * 4 + k < int'(bar_len_q)) begin
                quad_word.pix[k] = COLOR_BAR;       // Inside the bar.
            end else begin
                quad_word.pix[k] = COLOR_BG;
            end
        end
    end

    assign is_write = (state_q == S_WRITE);

    always_comb begin
        mem_req       = '0;
        mem_req.req   = (state_q == S_READ) || is_write;
        mem_req.we    = is_write;
        mem_req.addr  = is_write ? frame_addr : ring_addr;
        mem_req.wdata = quad_word;
    end

    //////////////////////////////
    // Frame sequencer.
    //////////////////////////////
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state_q     <= S_START;
            head_q      <= '0;
            row_q       <= '0;
            quad_q      <= '0;
            bar_len_q   <= '0;
            run_max_q   <= '0;
            run_min_q   <= 16'hFFFF;
            max_count   <= '0;
            min_count   <= 16'hFFFF;
            frame_start <= 1'b0;
            frame_done  <= 1'b0;
        end else begin
            frame_done <= 1'b0;                     // Pulse, also across a freeze.
            if (en) begin
                frame_start <= 1'b0;
                case (state_q)
                    S_START: begin
                        frame_start <= 1'b1;
                        row_q       <= '0;
                        run_max_q   <= '0;
                        run_min_q   <= 16'hFFFF;
                        state_q     <= S_LOG;
                    end
                    S_LOG: if (ring_pos.logged) begin
                        head_q  <= ring_pos.head;   // Row 0 is the oldest.
                        state_q <= S_READ;
                    end
                    S_READ: if (mem_rsp.done) begin
                        state_q <= S_BAR;           // Request drops here.
                    end
                    S_BAR: begin
                        bar_len_q <= bar_next;
                        quad_q    <= '0;
                        if (count_q > run_max_q) run_max_q <= count_q;
                        if (count_q < run_min_q) run_min_q <= count_q;
                        state_q   <= S_WRITE;
                    end
                    S_WRITE: if (mem_rsp.done) begin
                        state_q <= S_NEXT;
                    end
                    S_NEXT: begin
                        if (quad_q != QUAD_W'(QUADS - 1)) begin
                            quad_q  <= quad_q + 1'b1;
                            state_q <= S_WRITE;
                        end else if (row_q != PTR_W'(POINTS - 1)) begin
                            row_q   <= row_q + 1'b1;
                            state_q <= S_READ;
                        end else begin
                            state_q <= S_DONE;
                        end
                    end
                    S_DONE: begin
                        frame_done <= 1'b1;
                        max_count  <= run_max_q;
                        min_count  <= run_min_q;
                        state_q    <= S_START;
                    end
                    default: state_q <= S_START;
                endcase
            end
        end
    end

    // Ring count captured with the read done.
    always_ff @(posedge clk) begin
        if (en && state_q == S_READ && mem_rsp.done) begin
            count_q <= mem_rsp.rdata.sample.count;
        end
    end

    // Bar never wider than the plot.
    a_bar_cap: assert property (@(posedge clk) disable iff (!rst_n)
        int'(bar_len_q) <= PLOT_W);

endmodule

`default_nettype wire

//--- histo_top.sv
`timescale 1ns/1ps
`default_nettype none

module histo_top (
    input  logic                         clk,
    input  logic                         rst_n,
    input  logic                         en,
    input  logic                         data_update,
    input  logic [15:0]                  pulse_count,
    input  logic [1:0]                   gain_div,
    input  logic [histo_pkg::ADDR_W-1:0] scan_addr,
    output logic [63:0]                  scan_data,
    output logic                         frame_done,
    output logic [15:0]                  max_count,
    output logic [15:0]                  min_count
);
    import histo_pkg::*;

    logic      frame_start;                         // Painter to logger.
    ring_pos_t ring_pos;                            // Logger to painter.
    mem_req_t  log_req;
    mem_rsp_t  log_rsp;
    mem_req_t  paint_req;
    mem_rsp_t  paint_rsp;

    sample_logger u_logger (
        .clk         (clk),
        .rst_n       (rst_n),
        .en          (en),
        .data_update (data_update),
        .pulse_count (pulse_count),
        .frame_start (frame_start),
        .ring_pos    (ring_pos),
        .mem_req     (log_req),
        .mem_rsp     (log_rsp)
    );

    burst_ram u_ram (
        .clk       (clk),
        .rst_n     (rst_n),
        .log_req   (log_req),
        .log_rsp   (log_rsp),
        .paint_req (paint_req),
        .paint_rsp (paint_rsp),
        .scan_addr (scan_addr),
        .scan_data (scan_data)
    );

    trace_painter u_painter (
        .clk         (clk),
        .rst_n       (rst_n),
        .en          (en),
        .gain_div    (gain_div),
        .frame_start (frame_start),
        .ring_pos    (ring_pos),
        .mem_req     (paint_req),
        .mem_rsp     (paint_rsp),
        .frame_done  (frame_done),
        .max_count   (max_count),
        .min_count   (min_count)
    );

endmodule

`default_nettype wire

//--- histo_tb.sv
`timescale 1ns/1ps
`default_nettype none

module histo_tb;
    import histo_pkg::*;

    localparam int ROUNDS     = 40;
    localparam int CYCLE_NS   = 100;
    localparam int FRAME_CYC  = POINTS * (3 + 3 * QUADS) + 8;   // Read, bar, quad writes.
    localparam int SCAN_CYC   = MEM_DEPTH + 2;
    localparam int FREEZE_CYC = 32;
    localparam int LIMIT_CYC  = ROUNDS * (FRAME_CYC + SCAN_CYC + FREEZE_CYC)
                              + 2 * (MEM_DEPTH + 8) + 100;

    logic        clk;
    logic        rst_n;
    logic        en;
    logic        data_update;
    logic [15:0] pulse_count;
    logic [1:0]  gain_div;
    logic [7:0]  scan_addr;
    logic [63:0] scan_data;
    logic        frame_done;
    logic [15:0] max_count;
    logic [15:0] min_count;

    // Reference ring, oldest entry at model_head.
    logic [15:0] model_ring [POINTS];
    int          model_head;
    logic [15:0] cnt;
    logic [1:0]  gain;
    int          n_upd;

    histo_top dut0 (
        .clk         (clk),
        .rst_n       (rst_n),
        .en          (en),
        .data_update (data_update),
        .pulse_count (pulse_count),
        .gain_div    (gain_div),
        .scan_addr   (scan_addr),
        .scan_data   (scan_data),
        .frame_done  (frame_done),
        .max_count   (max_count),
        .min_count   (min_count)
    );

    always #50 clk = ~clk;                          // 100 ns period.

    //////////////////////////////
    // Helpers.
    //////////////////////////////
    task automatic check_value(input string name, input logic [63:0] got,
                               input logic [63:0] expected);
        if (got !== expected) begin
            $display("[ERROR] %s got %h expected %h", name, got, expected);
            $display("Test failed");
            $fatal(1);
        end
    endtask

    // Bar length in pixels, clamped to the plot width.
    function automatic int bar_length(input logic [15:0] count, input logic [1:0] g);
        int s;
        s = int'(count >> g);
        return (s > PLOT_W) ? PLOT_W : s;
    endfunction

    // Expected pixel quad q of a row with bar length len.
    function automatic logic [63:0] bar_quad(input int len, input int q);
        logic [63:0] w;
        for (int k = 0; k < 4; k++) begin
            w[16*k +: 16] = (q * 4 + k < len) ? COLOR_BAR : COLOR_BG;   // Pixel 0 low.
        end
        return w;
    endfunction

    // Count biased toward small values and the clamp edge.
    function automatic logic [15:0] random_count();
        case ($urandom % 8)
            0, 1, 2: return 16'($urandom % 40);
            3, 4:    return 16'($urandom % 300);
            5:       return 16'(PLOT_W << ($urandom % 4));   // Exact cap edge.
            6:       return 16'($urandom % 1024);
            default: return 16'($urandom);
        endcase
    endfunction

    task automatic scan_word(input int addr, output logic [63:0] word);
        scan_addr = 8'(addr);
        @(negedge clk);                             // Registered read.
        word = scan_data;
    endtask

    // Ring records, then every frame burst.
    task automatic check_memory(input logic [1:0] g);
        logic [63:0] word;
        int          idx;
        for (int a = 0; a < POINTS; a++) begin
            scan_word(RING_BASE + a, word);
            check_value($sformatf("ring[%0d]", a), word, {48'h0, model_ring[a]});
        end
        for (int r = 0; r < POINTS; r++) begin
            idx = (model_head + r) % POINTS;        // Row 0 is the oldest.
            for (int q = 0; q < QUADS; q++) begin
                scan_word(FRAME_BASE + r * QUADS + q, word);
                check_value($sformatf("frame[%0d][%0d]", r, q), word,
                            bar_quad(bar_length(model_ring[idx], g), q));
            end
        end
    endtask

    task automatic check_extremes();
        logic [15:0] mx;
        logic [15:0] mn;
        mx = 16'h0000;
        mn = 16'hFFFF;
        for (int i = 0; i < POINTS; i++) begin
            if (model_ring[i] > mx) mx = model_ring[i];
            if (model_ring[i] < mn) mn = model_ring[i];
        end
        check_value("max_count", max_count, mx);
        check_value("min_count", min_count, mn);
    endtask

    // Frozen phase with a few strobes. Leaves the last count in cnt.
    task automatic freeze_and_load(input int n, input logic force_clamp);
        for (int i = 0; i < n; i++) begin
            repeat ($urandom % 4) begin
                scan_addr = 8'($urandom);
                @(negedge clk);
                check_value("frame_done", frame_done, 1'b0);
            end
            cnt = random_count();
            if (force_clamp && i == n - 1) begin
                cnt = 16'(PLOT_W + 1 + $urandom % 231);   // Clamps at gain 0 only.
            end
            data_update = 1'b1;
            pulse_count = cnt;
            @(negedge clk);
            data_update = 1'b0;
            pulse_count = 16'($urandom);            // Junk between strobes.
            check_value("frame_done", frame_done, 1'b0);
        end
    endtask

    //////////////////////////////
    // Watchdog.
    //////////////////////////////
    initial begin
        #(LIMIT_CYC * CYCLE_NS);
        $display("Timeout: no frame completed within the allowed time");
        $display("Test failed");
        $fatal(1);
    end

    //////////////////////////////
    // Main sequence.
    //////////////////////////////
    initial begin
        void'($urandom(32'h8ca4_8575));
        clk         = 1'b0;
        rst_n       = 1'b0;
        en          = 1'b0;
        data_update = 1'b0;
        pulse_count = 16'h0000;
        gain_div    = 2'd0;
        scan_addr   = 8'h00;
        model_head  = 0;
        for (int i = 0; i < POINTS; i++) model_ring[i] = 16'h0000;

        repeat (2) @(negedge clk);
        rst_n = 1'b1;
        check_value("max_count", max_count, 16'h0000);
        check_value("min_count", min_count, 16'hFFFF);

        // Clear pass, then the whole map must read as blank.
        repeat (MEM_DEPTH + 4) @(negedge clk);
        check_memory(2'd0);
        check_value("max_count", max_count, 16'h0000);
        check_value("min_count", min_count, 16'hFFFF);

        for (int rnd = 0; rnd < ROUNDS; rnd++) begin
            gain     = (rnd < 4) ? 2'(rnd) : 2'($urandom);   // Every gain early on.
            gain_div = gain;
            n_upd    = 1 + $urandom % 4;
            freeze_and_load(n_upd, rnd == 0);

            en = 1'b1;
            do @(negedge clk); while (!frame_done);
            en = 1'b0;

            model_ring[model_head] = cnt;           // Overwrite the oldest.
            model_head = (model_head + 1) % POINTS;

            check_extremes();
            check_memory(gain);
        end

        $display("Test passed");
        $finish;
    end

endmodule

`default_nettype wire

//--- sources.f
histo_pkg.sv
sample_logger.sv
burst_ram.sv
trace_painter.sv
histo_top.sv
histo_tb.sv
